// ==== all.f ====
hw/dcachePkg.sv
hw/dcacheFsm.sv
hw/dcacheTagArray.sv
hw/dcacheDataArray.sv
hw/dcacheSetSelect.sv
hw/dcachePerfCounters.sv
hw/dcacheTop.sv
dv/busMemModel.sv
dv/dcacheTb.sv

// ==== dv/dcacheTb.sv ====
// data cache testbench: clock, reset, stimulus table, reference model, compare tasks, timeout
`timescale 1ns/100ps
`default_nettype none

module dcacheTb;

  localparam int addrWidth    = 16;
  localparam int numSets      = 8;
  localparam int wordsPerLine = 4;
  localparam int counterWidth = 16;
  localparam int wordWidth    = dcachePkg::wordWidth;
  localparam int indexWidth   = $clog2(numSets);
  localparam int wordSelWidth = $clog2(wordsPerLine);
  localparam int byteOfsWidth = $clog2(wordWidth / 8);
  localparam int offsetWidth  = wordSelWidth + byteOfsWidth;
  localparam int tagWidth     = addrWidth - indexWidth - offsetWidth;
  localparam int lineAdrWidth = addrWidth - offsetWidth;
  localparam int lineWidth    = wordWidth * wordsPerLine;
  localparam int numLines     = 2 ** lineAdrWidth;

  logic                    clk = 1'b0;
  logic                    reset;
  dcachePkg::memOp_t       op;
  logic [addrWidth-1:0]    adr;
  logic [wordWidth-1:0]    writeData;
  logic                    flush;
  logic [wordWidth-1:0]    readData;
  logic                    stall;
  logic                    busAck;
  logic                    busFetch;
  logic                    busWrite;
  logic [lineAdrWidth-1:0] busAdr;
  logic [lineWidth-1:0]    busReadData;
  logic [lineWidth-1:0]    busWriteData;
  logic [counterWidth-1:0] accessCount;
  logic [counterWidth-1:0] missCount;

  // stimulus table, one entry per request or flush
  string                tName [$];
  logic                 tFlush [$];
  dcachePkg::memOp_t    tOp [$];
  logic [addrWidth-1:0] tAdr [$];
  logic [wordWidth-1:0] tData [$];
  logic                 tMiss [$];

  // reference model, direct mapped image plus memory image
  logic [tagWidth-1:0]  refTag [numSets];
  logic                 refValid [numSets];
  logic                 refDirty [numSets];
  logic [lineWidth-1:0] refLine [numSets];
  logic [lineWidth-1:0] refMem [numLines];
  logic [wordWidth-1:0] expRead;
  int                   refAccess = 0;
  int                   refMiss = 0;

  // bus transfers, expected and seen, write flag then address then line
  logic                    expIsWrite [$];
  logic [lineAdrWidth-1:0] expAdr [$];
  logic [lineWidth-1:0]    expLine [$];
  logic                    evIsWrite [$];
  logic [lineAdrWidth-1:0] evAdr [$];
  logic [lineWidth-1:0]    evLine [$];

  int errors = 0;
  int checks = 0;
  int cycleCount = 0;
  int timeoutLimit = 100000;

  always #2 clk = ~clk;

  dcacheTop #(
    .addrWidth(addrWidth), .numSets(numSets), .wordsPerLine(wordsPerLine),
    .counterWidth(counterWidth)
  ) u_dut (
    .clk, .reset, .op, .adr, .writeData, .flush, .readData, .stall,
    .busAck, .busReadData, .busFetch, .busWrite, .busAdr, .busWriteData,
    .accessCount, .missCount
  );

  busMemModel #(.lineAdrWidth(lineAdrWidth), .lineWidth(lineWidth), .ackDelay(3)) u_mem (
    .clk, .reset, .busFetch, .busWrite, .busAdr, .busWriteData, .busAck, .busReadData
  );

  ////////////////////////////////////////
  // bus monitor and timeout
  ////////////////////////////////////////

  // strobes are sampled before the edge updates anything
  always @(posedge clk) begin
    if (busWrite) begin
      evIsWrite.push_back(1'b1);
      evAdr.push_back(busAdr);
      evLine.push_back(busWriteData);
    end
    if (busFetch) begin
      evIsWrite.push_back(1'b0);
      evAdr.push_back(busAdr);
      evLine.push_back('0);
    end
  end

  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= timeoutLimit) begin
      $display("timeout: the cache did not finish within %0d cycles", timeoutLimit);
      $display("TEST FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////

  task automatic checkWord(input string name, input logic [wordWidth-1:0] exp, act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic checkCount(input string name, input logic [counterWidth-1:0] exp, act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("CHECK FAILED %s: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  task automatic checkLine(input string name, input logic [lineWidth-1:0] exp, act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic checkLineAdr(input string name, input logic [lineAdrWidth-1:0] exp, act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic checkBit(input string name, input logic exp, act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("CHECK FAILED %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  ////////////////////////////////////////
  // stimulus table
  ////////////////////////////////////////

  task automatic addEntry(input string name, input logic isFlush, input dcachePkg::memOp_t entryOp,
                          input logic [addrWidth-1:0] entryAdr, input logic [wordWidth-1:0] data,
                          input logic miss);
    tName.push_back(name);
    tFlush.push_back(isFlush);
    tOp.push_back(entryOp);
    tAdr.push_back(entryAdr);
    tData.push_back(data);
    tMiss.push_back(miss);
  endtask

  // address split: tag [15:7], set [6:4], word [3:2]
  task automatic buildTable();
    addEntry("readCold",        0, dcachePkg::opRead,  16'h0010, 32'h0,         1);
    addEntry("readHit",         0, dcachePkg::opRead,  16'h0018, 32'h0,         0);
    addEntry("writeHit",        0, dcachePkg::opWrite, 16'h0014, 32'hA5A5_0001, 0);
    addEntry("readBackHit",     0, dcachePkg::opRead,  16'h0014, 32'h0,         0);
    addEntry("writeColdSet2",   0, dcachePkg::opWrite, 16'h0124, 32'h1234_5678, 1);
    addEntry("readEvictDirty",  0, dcachePkg::opRead,  16'h0090, 32'h0,         1);
    addEntry("readAfterEvict",  0, dcachePkg::opRead,  16'h0014, 32'h0,         1);
    addEntry("writeColdSet5",   0, dcachePkg::opWrite, 16'h0258, 32'hCAFE_0005, 1);
    addEntry("writeHitSet5",    0, dcachePkg::opWrite, 16'h025C, 32'hBEEF_0006, 0);
    addEntry("flushDirty",      1, dcachePkg::opNone,  16'h0000, 32'h0,         0);
    addEntry("flushClean",      1, dcachePkg::opNone,  16'h0000, 32'h0,         0);
    addEntry("readAfterFlush",  0, dcachePkg::opRead,  16'h0124, 32'h0,         0);
    addEntry("writeCleanVict",  0, dcachePkg::opWrite, 16'h0020, 32'h0BAD_F00D, 1);
    addEntry("flushOneLine",    1, dcachePkg::opNone,  16'h0000, 32'h0,         0);
  endtask

  ////////////////////////////////////////
  // reference model
  ////////////////////////////////////////

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // same random lines go to the memory model and the memory image
  task automatic fillMemory();
    logic [31:0]          rng;
    logic [lineWidth-1:0] line;
    rng = 32'd53;
    for (int a = 0; a < numLines; a++) begin
      for (int w = 0; w < wordsPerLine; w++) begin
        rng = xorshift(rng);
        line[w*wordWidth +: wordWidth] = rng ^ 32'(a * wordsPerLine + w);
      end
      u_mem.mem[a] = line;
      refMem[a] = line;
    end
  endtask

  // victim line goes to memory first
  task automatic evictLine(input logic [indexWidth-1:0] set);
    expIsWrite.push_back(1'b1);
    expAdr.push_back({refTag[set], set});
    expLine.push_back(refLine[set]);
    refMem[{refTag[set], set}] = refLine[set];
  endtask

  task automatic predict(input int i);
    logic [indexWidth-1:0] set;
    logic [tagWidth-1:0]   tag;
    int                    wsel;
    expIsWrite.delete();
    expAdr.delete();
    expLine.delete();
    expRead = '0;
    if (tFlush[i]) begin
      // sets walked in order, only dirty ones reach the bus
      for (int s = 0; s < numSets; s++) begin
        if (refValid[s] && refDirty[s]) begin
          evictLine(indexWidth'(s));
          refDirty[s] = 1'b0;
        end
      end
    end else begin
      set = tAdr[i][offsetWidth +: indexWidth];
      tag = tAdr[i][addrWidth-1 -: tagWidth];
      wsel = tAdr[i][byteOfsWidth +: wordSelWidth];
      refAccess++;
      if (!(refValid[set] && refTag[set] == tag)) begin
        refMiss++;
        if (refValid[set] && refDirty[set]) begin
          evictLine(set);
        end
        expIsWrite.push_back(1'b0);
        expAdr.push_back({tag, set});
        expLine.push_back('0);
        refLine[set] = refMem[{tag, set}];
        refTag[set] = tag;
        refValid[set] = 1'b1;
        refDirty[set] = 1'b0;
      end
      if (tOp[i] == dcachePkg::opWrite) begin
        refLine[set][wsel*wordWidth +: wordWidth] = tData[i];
        refDirty[set] = 1'b1;
      end
      expRead = refLine[set][wsel*wordWidth +: wordWidth];
    end
  endtask

  ////////////////////////////////////////
  // table entry runner
  ////////////////////////////////////////

  task automatic runEntry(input int i);
    int                   waitCycles;
    int                   fetches;
    logic [wordWidth-1:0] got;
    predict(i);
    @(negedge clk);
    evIsWrite.delete();
    evAdr.delete();
    evLine.delete();
    flush = tFlush[i];
    op = tOp[i];
    adr = tAdr[i];
    writeData = tData[i];
    // the accepting edge is the first one with stall low
    waitCycles = 0;
    @(posedge clk);
    while (stall) begin
      waitCycles++;
      @(posedge clk);
    end
    got = readData;
    @(negedge clk);
    flush = 1'b0;
    op = dcachePkg::opNone;
    if (tOp[i] == dcachePkg::opRead) begin
      checkWord({tName[i], " read data"}, expRead, got);
    end
    // hits complete in the request cycle
    if (!tFlush[i] && !tMiss[i]) begin
      checkCount({tName[i], " stall cycles"}, '0, counterWidth'(waitCycles));
    end
    fetches = 0;
    foreach (evIsWrite[k]) begin
      if (!evIsWrite[k]) begin
        fetches++;
      end
    end
    checkBit({tName[i], " miss"}, tMiss[i], fetches != 0);
    checkCount({tName[i], " bus transfers"}, counterWidth'(expAdr.size()),
               counterWidth'(evAdr.size()));
    for (int k = 0; k < expAdr.size() && k < evAdr.size(); k++) begin
      checkBit({tName[i], " bus write"}, expIsWrite[k], evIsWrite[k]);
      checkLineAdr({tName[i], " bus address"}, expAdr[k], evAdr[k]);
      if (expIsWrite[k]) begin
        checkLine({tName[i], " write back line"}, expLine[k], evLine[k]);
      end
    end
    checkCount({tName[i], " access count"}, counterWidth'(refAccess), accessCount);
    checkCount({tName[i], " miss count"}, counterWidth'(refMiss), missCount);
    // memory changes only by write backs
    checks++;
    for (int a = 0; a < numLines; a++) begin
      if (u_mem.mem[a] !== refMem[a]) begin
        checkLine($sformatf("%s memory line %h", tName[i], a[lineAdrWidth-1:0]),
                  refMem[a], u_mem.mem[a]);
      end
    end
  endtask

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////

  initial begin
    int flushEntries;
    reset = 1'b1;
    op = dcachePkg::opNone;
    adr = '0;
    writeData = '0;
    flush = 1'b0;
    buildTable();
    flushEntries = 0;
    foreach (tFlush[i]) begin
      if (tFlush[i]) begin
        flushEntries++;
      end
    end
    timeoutLimit = 20 + 20 * tName.size() + 20 * numSets * flushEntries;
    fillMemory();
    for (int s = 0; s < numSets; s++) begin
      refValid[s] = 1'b0;
      refDirty[s] = 1'b0;
    end
    repeat (2) @(negedge clk);
    reset = 1'b0;
    // idle outputs right after reset
    @(posedge clk);
    checkBit("reset stall", 1'b0, stall);
    checkBit("reset busFetch", 1'b0, busFetch);
    checkBit("reset busWrite", 1'b0, busWrite);
    checkCount("reset access count", '0, accessCount);
    checkCount("reset miss count", '0, missCount);
    for (int i = 0; i < tName.size(); i++) begin
      runEntry(i);
    end
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== dv/busMemModel.sv ====
// line wide backing memory for the data cache bus: strobe capture and delayed ack
`timescale 1ns/100ps
`default_nettype none

module busMemModel #(
  parameter int lineAdrWidth = 12,
  parameter int lineWidth    = 128,
  parameter int ackDelay     = 3
) (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    busFetch,
  input  logic                    busWrite,
  input  logic [lineAdrWidth-1:0] busAdr,
  input  logic [lineWidth-1:0]    busWriteData,
  output logic                    busAck,
  output logic [lineWidth-1:0]    busReadData
);

  // one entry per line address, loaded by the testbench
  logic [lineWidth-1:0]    mem [2**lineAdrWidth];
  logic [lineAdrWidth-1:0] pendAdr;
  logic                    pendFetch;
  int                      delayCnt;

  always @(posedge clk) begin
    if (reset) begin
      busAck      <= 1'b0;
      busReadData <= '0;
      pendFetch   <= 1'b0;
      delayCnt    <= 0;
    end else begin
      busAck <= 1'b0;
      if (busFetch || busWrite) begin
        // ack lands ackDelay cycles after the strobe cycle
        pendAdr   <= busAdr;
        pendFetch <= busFetch;
        delayCnt  <= ackDelay - 1;
        if (busWrite) begin
          mem[busAdr] <= busWriteData;
        end
      end else if (delayCnt != 0) begin
        delayCnt <= delayCnt - 1;
        if (delayCnt == 1) begin
          busAck <= 1'b1;
          // read data only valid in the ack cycle
          if (pendFetch) begin
            busReadData <= mem[pendAdr];
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== hw/dcacheTop.sv ====
// data cache top level: controller, tag and line stores, set select and perf counters
`timescale 1ns/100ps
`default_nettype none

module dcacheTop #(
  parameter  int addrWidth    = 16,
  parameter  int numSets      = 8,
  parameter  int wordsPerLine = 4,
  parameter  int counterWidth = 16,
  localparam int indexWidth   = $clog2(numSets),
  localparam int offsetWidth  = $clog2(wordsPerLine) + $clog2(dcachePkg::wordWidth / 8),
  localparam int lineAdrWidth = addrWidth - offsetWidth,
  localparam int lineWidth    = dcachePkg::wordWidth * wordsPerLine
) (
  input  logic                            clk,
  input  logic                            reset,
  // cpu side
  input  dcachePkg::memOp_t               op,
  input  logic [addrWidth-1:0]            adr,
  input  logic [dcachePkg::wordWidth-1:0] writeData,
  input  logic                            flush,
  output logic [dcachePkg::wordWidth-1:0] readData,
  output logic                            stall,
  // bus side, whole lines
  input  logic                            busAck,
  input  logic [lineWidth-1:0]            busReadData,
  output logic                            busFetch,
  output logic                            busWrite,
  output logic [lineAdrWidth-1:0]         busAdr,
  output logic [lineWidth-1:0]            busWriteData,
  // perf counters
  output logic [counterWidth-1:0]         accessCount,
  output logic [counterWidth-1:0]         missCount
);

  logic                  hit;
  logic                  victimDirty;
  logic                  flushDone;
  logic                  selFlush;
  logic                  selVictimAdr;
  logic                  fillLine;
  logic                  wordWrite;
  logic                  setValidClean;
  logic                  setDirty;
  logic                  clearDirty;
  logic                  flushCntEn;
  logic                  flushCntRst;
  logic                  countAccess;
  logic                  countMiss;
  logic [indexWidth-1:0] setIndex;

  ////////////////////////////////////////
  // controller
  ////////////////////////////////////////

  dcacheFsm u_fsm (
    .clk, .reset, .op, .flush, .hit, .victimDirty, .flushDone, .busAck,
    .stall, .selFlush, .selVictimAdr, .fillLine, .wordWrite,
    .setValidClean, .setDirty, .clearDirty, .flushCntEn, .flushCntRst,
    .busFetch, .busWrite, .countAccess, .countMiss
  );

  ////////////////////////////////////////
  // storage and indexing
  ////////////////////////////////////////

  // both stores see the same set, cpu index or flush counter
  dcacheSetSelect #(.addrWidth(addrWidth), .numSets(numSets), .wordsPerLine(wordsPerLine))
    u_setSelect (
      .clk, .reset, .adr, .selFlush, .flushCntEn, .flushCntRst, .setIndex, .flushDone
    );

  dcacheTagArray #(.addrWidth(addrWidth), .numSets(numSets), .wordsPerLine(wordsPerLine))
    u_tagArray (
      .clk, .reset, .adr, .setIndex, .setValidClean, .setDirty, .clearDirty,
      .selVictimAdr, .hit, .victimDirty, .busAdr
    );

  dcacheDataArray #(.addrWidth(addrWidth), .numSets(numSets), .wordsPerLine(wordsPerLine))
    u_dataArray (
      .clk, .adr, .setIndex, .writeData, .busReadData, .fillLine, .wordWrite,
      .readData, .busWriteData
    );

  // access and miss counts beside the controller
  dcachePerfCounters #(.counterWidth(counterWidth)) u_perfCounters (
    .clk, .reset, .countAccess, .countMiss, .accessCount, .missCount
  );

endmodule

`default_nettype wire

// ==== hw/dcachePerfCounters.sv ====
// data cache performance counters: saturating access and miss counts
`timescale 1ns/100ps
`default_nettype none

module dcachePerfCounters #(
  parameter int counterWidth = 16
) (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    countAccess,
  input  logic                    countMiss,
  output logic [counterWidth-1:0] accessCount,
  output logic [counterWidth-1:0] missCount
);

  // one step up, sticks at all ones
  function automatic logic [counterWidth-1:0] stepSat(input logic [counterWidth-1:0] count);
    stepSat = (&count) ? count : count + 1'b1;
  endfunction

  always_ff @(posedge clk) begin
    if (reset) begin
      accessCount <= '0;
      missCount   <= '0;
    end else begin
      if (countAccess) begin
        accessCount <= stepSat(accessCount);
      end
      // a miss strobe comes with its access strobe
      if (countMiss) begin
        missCount <= stepSat(missCount);
      end
    end
  end

endmodule

`default_nettype wire

// ==== hw/dcacheSetSelect.sv ====
// data cache set select: flush set counter with done flag, set index mux
`timescale 1ns/100ps
`default_nettype none

module dcacheSetSelect #(
  parameter  int addrWidth    = 16,
  parameter  int numSets      = 8,
  parameter  int wordsPerLine = 4,
  localparam int indexWidth   = $clog2(numSets),
  localparam int offsetWidth  = $clog2(wordsPerLine) + $clog2(dcachePkg::wordWidth / 8)
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic [addrWidth-1:0]  adr,
  input  logic                  selFlush,
  input  logic                  flushCntEn,
  input  logic                  flushCntRst,
  output logic [indexWidth-1:0] setIndex,
  output logic                  flushDone
);

  logic [indexWidth-1:0] flushCnt;

  // walks sets 0 to numSets-1 during a flush
  always_ff @(posedge clk) begin
    if (reset || flushCntRst) begin
      flushCnt <= '0;
    end else if (flushCntEn) begin
      flushCnt <= flushCnt + 1'b1;
    end
  end

  assign flushDone = (flushCnt == indexWidth'(numSets - 1));
  assign setIndex  = selFlush ? flushCnt : adr[offsetWidth +: indexWidth];

endmodule

`default_nettype wire

// ==== hw/dcacheDataArray.sv ====
// data cache line store: line per set with word write, line fill and word read
`timescale 1ns/100ps
`default_nettype none

module dcacheDataArray #(
  parameter  int addrWidth      = 16,
  parameter  int numSets        = 8,
  parameter  int wordsPerLine   = 4,
  localparam int indexWidth     = $clog2(numSets),
  localparam int wordSelWidth   = $clog2(wordsPerLine),
  localparam int byteOfsWidth   = $clog2(dcachePkg::wordWidth / 8),
  localparam int lineWidth      = dcachePkg::wordWidth * wordsPerLine
) (
  input  logic                           clk,
  input  logic [addrWidth-1:0]           adr,
  input  logic [indexWidth-1:0]          setIndex,
  input  logic [dcachePkg::wordWidth-1:0] writeData,
  input  logic [lineWidth-1:0]           busReadData,
  input  logic                           fillLine,
  input  logic                           wordWrite,
  output logic [dcachePkg::wordWidth-1:0] readData,
  output logic [lineWidth-1:0]           busWriteData
);

  logic [lineWidth-1:0]    lines [numSets];
  logic [wordSelWidth-1:0] wordSel;
  logic [lineWidth-1:0]    selLine;

  // word within the line, byte offset dropped
  assign wordSel = adr[byteOfsWidth +: wordSelWidth];
  assign selLine = lines[setIndex];

  // combinational read, valid in the request cycle
  assign readData     = selLine[wordSel*dcachePkg::wordWidth +: dcachePkg::wordWidth];
  assign busWriteData = selLine;

  // fill and word write never coincide, fill takes the whole line
  always_ff @(posedge clk) begin
    if (fillLine) begin
      lines[setIndex] <= busReadData;
    end else if (wordWrite) begin
      lines[setIndex][wordSel*dcachePkg::wordWidth +: dcachePkg::wordWidth] <= writeData;
    end
  end

endmodule

`default_nettype wire

// ==== hw/dcacheTagArray.sv ====
// data cache tag store: tag, valid and dirty per set, hit and victim dirty, bus line address
`timescale 1ns/100ps
`default_nettype none

module dcacheTagArray #(
  parameter  int addrWidth    = 16,
  parameter  int numSets      = 8,
  parameter  int wordsPerLine = 4,
  localparam int indexWidth   = $clog2(numSets),
  localparam int offsetWidth  = $clog2(wordsPerLine) + $clog2(dcachePkg::wordWidth / 8),
  localparam int tagWidth     = addrWidth - indexWidth - offsetWidth,
  localparam int lineAdrWidth = addrWidth - offsetWidth
) (
  input  logic                    clk,
  input  logic                    reset,
  input  logic [addrWidth-1:0]    adr,
  input  logic [indexWidth-1:0]   setIndex,
  input  logic                    setValidClean,
  input  logic                    setDirty,
  input  logic                    clearDirty,
  input  logic                    selVictimAdr,
  output logic                    hit,
  output logic                    victimDirty,
  output logic [lineAdrWidth-1:0] busAdr
);

  logic [tagWidth-1:0]   tags [numSets];
  logic [numSets-1:0]    valid;
  logic [numSets-1:0]    dirty;
  logic [tagWidth-1:0]   adrTag;
  logic [tagWidth-1:0]   storedTag;

  assign adrTag    = adr[addrWidth-1 -: tagWidth];
  assign storedTag = tags[setIndex];

  // lookup on whatever set is selected, cpu index or flush counter
  assign hit         = valid[setIndex] & (storedTag == adrTag);
  assign victimDirty = valid[setIndex] & dirty[setIndex];

  // victim line for write backs, requested line for fetches
  assign busAdr = selVictimAdr ? {storedTag, setIndex} : adr[addrWidth-1:offsetWidth];

  // tag written on fill only
  always_ff @(posedge clk) begin
    if (setValidClean) begin
      tags[setIndex] <= adrTag;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      valid <= '0;
      dirty <= '0;
    end else begin
      if (setValidClean) begin
        valid[setIndex] <= 1'b1;
        dirty[setIndex] <= 1'b0;
      end
      if (setDirty) begin
        dirty[setIndex] <= 1'b1;
      end
      if (clearDirty) begin
        dirty[setIndex] <= 1'b0;
      end
    end
  end

  // controller never sets and clears a dirty bit in one cycle
  assert property (@(posedge clk) disable iff (reset) !(setDirty && clearDirty));

endmodule

`default_nettype wire

// ==== hw/dcacheFsm.sv ====
// data cache controller FSM: hit, miss, eviction and flush sequencing with bus strobes
`timescale 1ns/100ps
`default_nettype none

module dcacheFsm (
  input  logic              clk,
  input  logic              reset,
  // cpu request
  input  dcachePkg::memOp_t op,
  input  logic              flush,
  // from the tag array and set select
  input  logic              hit,
  input  logic              victimDirty,
  input  logic              flushDone,
  // bus answer
  input  logic              busAck,
  output logic              stall,
  // array and counter control
  output logic              selFlush,
  output logic              selVictimAdr,
  output logic              fillLine,
  output logic              wordWrite,
  output logic              setValidClean,
  output logic              setDirty,
  output logic              clearDirty,
  output logic              flushCntEn,
  output logic              flushCntRst,
  // bus strobes
  output logic              busFetch,
  output logic              busWrite,
  // perf counter strobes
  output logic              countAccess,
  output logic              countMiss
);

  dcachePkg::cacheState_t state;
  dcachePkg::cacheState_t nextState;
  logic                   cpuReq;
  // a strobe went out in this wait state and its ack is still due
  logic                   strobeSent;

  assign cpuReq = (op != dcachePkg::opNone);

  // flush wins over op, so a flush cycle is not a counted access
  assign countAccess = (state == dcachePkg::stReady) & cpuReq & ~flush;
  assign countMiss   = countAccess & ~hit;

  ////////////////////////////////////////
  // state and strobe bookkeeping
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= dcachePkg::stReady;
    end else begin
      state <= nextState;
    end
  end

  // strobes fire in the first cycle of a wait state only
  always_ff @(posedge clk) begin
    if (reset) begin
      strobeSent <= 1'b0;
    end else if (busAck) begin
      strobeSent <= 1'b0;
    end else if (busFetch | busWrite) begin
      strobeSent <= 1'b1;
    end
  end

  ////////////////////////////////////////
  // next state and outputs
  ////////////////////////////////////////

  always_comb begin
    nextState     = state;
    stall         = 1'b0;
    selFlush      = 1'b0;
    selVictimAdr  = 1'b0;
    fillLine      = 1'b0;
    wordWrite     = 1'b0;
    setValidClean = 1'b0;
    setDirty      = 1'b0;
    clearDirty    = 1'b0;
    flushCntEn    = 1'b0;
    flushCntRst   = 1'b0;
    busFetch      = 1'b0;
    busWrite      = 1'b0;

    case (state)
      dcachePkg::stReady: begin
        if (flush) begin
          // counter back to set 0, scan starts next cycle
          stall       = 1'b1;
          flushCntRst = 1'b1;
          nextState   = dcachePkg::stFlushScan;
        end else if (cpuReq & ~hit) begin
          // one way only, so the victim must leave before the fetch
          stall     = 1'b1;
          nextState = victimDirty ? dcachePkg::stEvict : dcachePkg::stFetch;
        end else if (op == dcachePkg::opWrite) begin
          // write hit lands at this edge
          wordWrite = 1'b1;
          setDirty  = 1'b1;
        end
      end

      dcachePkg::stEvict: begin
        // busAdr shows the stored tag until the ack
        stall        = 1'b1;
        selVictimAdr = 1'b1;
        busWrite     = ~strobeSent;
        if (busAck) begin
          nextState = dcachePkg::stFetch;
        end
      end

      dcachePkg::stFetch: begin
        stall    = 1'b1;
        busFetch = ~strobeSent;
        // bus data is only there in the ack cycle
        if (busAck) begin
          fillLine  = 1'b1;
          nextState = dcachePkg::stFill;
        end
      end

      dcachePkg::stFill: begin
        // new tag, valid and clean, hit shows up next cycle
        stall         = 1'b1;
        setValidClean = 1'b1;
        nextState     = dcachePkg::stMissDone;
      end

      dcachePkg::stMissDone: begin
        // stall low, read data valid or write stored at this edge
        if (op == dcachePkg::opWrite) begin
          wordWrite = 1'b1;
          setDirty  = 1'b1;
        end
        nextState = dcachePkg::stReady;
      end

      dcachePkg::stFlushScan: begin
        stall        = 1'b1;
        selFlush     = 1'b1;
        selVictimAdr = 1'b1;
        if (victimDirty) begin
          nextState = dcachePkg::stFlushWriteBack;
        end else if (flushDone) begin
          stall     = 1'b0;
          nextState = dcachePkg::stReady;
        end else begin
          flushCntEn = 1'b1;
        end
      end

      dcachePkg::stFlushWriteBack: begin
        stall        = 1'b1;
        selFlush     = 1'b1;
        selVictimAdr = 1'b1;
        busWrite     = ~strobeSent;
        if (busAck) begin
          nextState = dcachePkg::stFlushClearDirty;
        end
      end

      dcachePkg::stFlushClearDirty: begin
        stall      = 1'b1;
        selFlush   = 1'b1;
        clearDirty = 1'b1;
        if (flushDone) begin
          stall     = 1'b0;
          nextState = dcachePkg::stReady;
        end else begin
          flushCntEn = 1'b1;
          nextState  = dcachePkg::stFlushScan;
        end
      end

      default: begin
        nextState = dcachePkg::stReady;
      end
    endcase
  end

  ////////////////////////////////////////
  // checks
  ////////////////////////////////////////

  // one transfer on the bus at a time
  assert property (@(posedge clk) disable iff (reset) !(busFetch && busWrite));

  // an ack always answers a strobe from the current wait state
  assert property (@(posedge clk) disable iff (reset)
    busAck |-> strobeSent && (state inside {dcachePkg::stEvict, dcachePkg::stFetch,
                                            dcachePkg::stFlushWriteBack}));

  // the cpu is released only on a hit, in stReady or once the fill is in
  assert property (@(posedge clk) disable iff (reset)
    (!stall && cpuReq && !flush) |-> hit);

endmodule

`default_nettype wire

// ==== hw/dcachePkg.sv ====
// shared data cache definitions: word width, cpu opcode enum, controller state enum
`default_nettype none

package dcachePkg;

  ////////////////////////////////////////
  // data path
  ////////////////////////////////////////

  // cpu data word, byte addressed
  localparam int wordWidth = 32;

  ////////////////////////////////////////
  // cpu request opcodes
  ////////////////////////////////////////

  // level encoded, held by the cpu while stall is high
  typedef enum logic [1:0] {
    opNone  = 2'b00,
    opRead  = 2'b01,
    opWrite = 2'b10
  } memOp_t;

  ////////////////////////////////////////
  // controller states
  ////////////////////////////////////////

  typedef enum logic [2:0] {
    // idle, hits complete here
    stReady,
    // dirty victim going out to the bus
    stEvict,
    // new line coming in from the bus
    stFetch,
    // tag and valid update after the line landed
    stFill,
    // miss completes, pending write goes in
    stMissDone,
    // walk the sets looking for dirty lines
    stFlushScan,
    stFlushWriteBack,
    stFlushClearDirty
  } cacheState_t;

endpackage

`default_nettype wire
